// ==== l2cache.f ====
rtl/l2cache_pkg.sv
rtl/line_array.sv
rtl/pseudo_lru.sv
rtl/l2cache_datapath.sv
rtl/l2cache_control.sv
rtl/l2cache.sv
verification/pmem_model.sv
verification/l2cache_tb.sv

// ==== rtl/l2cache.sv ====
`default_nettype none

module l2cache (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mem_req,
    input  logic               mem_write,
    input  l2cache_pkg::addr_t mem_address,
    input  l2cache_pkg::line_t mem_wdata,
    output logic               mem_resp,
    output l2cache_pkg::line_t mem_rdata,
    output logic               pmem_read,
    output logic               pmem_write,
    output l2cache_pkg::addr_t pmem_address,
    output l2cache_pkg::line_t pmem_wdata,
    input  l2cache_pkg::line_t pmem_rdata,
    input  logic               pmem_resp
);

    // control to datapath
    logic capture_req;
    logic way_sel_lru;
    logic load_line;
    logic line_from_mem;
    logic load_valid;
    logic load_dirty;
    logic dirty_in;
    logic load_lru;
    logic load_wb;
    logic addr_from_wb;

    // datapath status
    logic hit;
    logic victim_dirty;
    logic req_write;

    l2cache_control control0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_req       (mem_req),
        .pmem_resp     (pmem_resp),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .req_write     (req_write),
        .mem_resp      (mem_resp),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .capture_req   (capture_req),
        .way_sel_lru   (way_sel_lru),
        .load_line     (load_line),
        .line_from_mem (line_from_mem),
        .load_valid    (load_valid),
        .load_dirty    (load_dirty),
        .dirty_in      (dirty_in),
        .load_lru      (load_lru),
        .load_wb       (load_wb),
        .addr_from_wb  (addr_from_wb)
    );

    l2cache_datapath datapath0 (
        .clk           (clk),
        .arst_n        (arst_n),
        .mem_write     (mem_write),
        .mem_address   (mem_address),
        .mem_wdata     (mem_wdata),
        .mem_rdata     (mem_rdata),
        .pmem_address  (pmem_address),
        .pmem_wdata    (pmem_wdata),
        .pmem_rdata    (pmem_rdata),
        .capture_req   (capture_req),
        .way_sel_lru   (way_sel_lru),
        .load_line     (load_line),
        .line_from_mem (line_from_mem),
        .load_valid    (load_valid),
        .load_dirty    (load_dirty),
        .dirty_in      (dirty_in),
        .load_lru      (load_lru),
        .load_wb       (load_wb),
        .addr_from_wb  (addr_from_wb),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .req_write     (req_write)
    );

endmodule

`default_nettype wire

// ==== rtl/l2cache_control.sv ====
`default_nettype none

module l2cache_control (
    input  logic clk,
    input  logic arst_n,
    input  logic mem_req,
    input  logic pmem_resp,
    input  logic hit,
    input  logic victim_dirty,
    input  logic req_write,
    output logic mem_resp,
    output logic pmem_read,
    output logic pmem_write,
    output logic capture_req,
    output logic way_sel_lru,
    output logic load_line,
    output logic line_from_mem,
    output logic load_valid,
    output logic load_dirty,
    output logic dirty_in,
    output logic load_lru,
    output logic load_wb,
    output logic addr_from_wb
);

    typedef enum logic [1:0] {
        idle,
        lookup,
        write_back,
        fill
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next    = state;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        capture_req   = 1'b0;
        way_sel_lru   = 1'b0;
        load_line     = 1'b0;
        line_from_mem = 1'b0;
        load_valid    = 1'b0;
        load_dirty    = 1'b0;
        dirty_in      = 1'b0;
        load_lru      = 1'b0;
        load_wb       = 1'b0;
        addr_from_wb  = 1'b0;

        case (state)
            idle: begin
                capture_req = mem_req;
                if (mem_req) begin
                    state_next = lookup;
                end
            end

            lookup: begin
                if (hit) begin
                    mem_resp   = 1'b1;
                    load_lru   = 1'b1;
                    load_line  = req_write;
                    load_dirty = req_write;
                    dirty_in   = 1'b1;
                    state_next = idle;
                end else begin
                    way_sel_lru = 1'b1;
                    if (victim_dirty) begin
                        load_wb    = 1'b1;
                        state_next = write_back;
                    end else if (req_write) begin
                        // a whole-line write needs no fetch
                        load_line  = 1'b1;
                        load_valid = 1'b1;
                        load_dirty = 1'b1;
                        dirty_in   = 1'b1;
                        load_lru   = 1'b1;
                        mem_resp   = 1'b1;
                        state_next = idle;
                    end else begin
                        state_next = fill;
                    end
                end
            end

            write_back: begin
                pmem_write   = 1'b1;
                addr_from_wb = 1'b1;
                way_sel_lru  = 1'b1;
                if (pmem_resp) begin
                    // victim is clean now so retry as a clean miss
                    load_dirty = 1'b1;
                    state_next = lookup;
                end
            end

            fill: begin
                pmem_read   = 1'b1;
                way_sel_lru = 1'b1;
                if (pmem_resp) begin
                    load_line     = 1'b1;
                    line_from_mem = 1'b1;
                    load_valid    = 1'b1;
                    load_dirty    = 1'b1;
                    state_next    = lookup;
                end
            end

            default: begin
                state_next = idle;
            end
        endcase
    end

    a_pmem_exclusive: assert property (
        @(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write))
        else $error("pmem_read and pmem_write both high");

    // requester must wait for mem_resp before the next strobe
    a_req_in_idle: assert property (
        @(posedge clk) disable iff (!arst_n) mem_req |-> state == idle)
        else $error("mem_req while an access is in progress");

    a_resp_pulse: assert property (
        @(posedge clk) disable iff (!arst_n) mem_resp |=> !mem_resp)
        else $error("mem_resp wider than one cycle");

endmodule

`default_nettype wire

// ==== rtl/l2cache_datapath.sv ====
`default_nettype none

module l2cache_datapath (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               mem_write,
    input  l2cache_pkg::addr_t mem_address,
    input  l2cache_pkg::line_t mem_wdata,
    output l2cache_pkg::line_t mem_rdata,
    output l2cache_pkg::addr_t pmem_address,
    output l2cache_pkg::line_t pmem_wdata,
    input  l2cache_pkg::line_t pmem_rdata,
    input  logic               capture_req,
    input  logic               way_sel_lru,
    input  logic               load_line,
    input  logic               line_from_mem,
    input  logic               load_valid,
    input  logic               load_dirty,
    input  logic               dirty_in,
    input  logic               load_lru,
    input  logic               load_wb,
    input  logic               addr_from_wb,
    output logic               hit,
    output logic               victim_dirty,
    output logic               req_write
);
    import l2cache_pkg::*;

    addr_t req_address;
    line_t req_wdata;
    tag_t  req_tag;
    idx_t  req_idx;

    tag_t  [num_ways-1:0] way_tags;
    line_t [num_ways-1:0] way_lines;
    logic  [num_ways-1:0] way_valid;
    logic  [num_ways-1:0] way_dirty;
    logic  [num_ways-1:0] hit_vec;

    way_t  hit_way;
    way_t  lru_way;
    way_t  way_sel;
    line_t line_in;
    addr_t wb_address;
    line_t wb_line;

    // captured request address and write flag
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_address <= '0;
            req_write   <= 1'b0;
        end else if (capture_req) begin
            req_address <= mem_address;
            req_write   <= mem_write;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_req) begin
            req_wdata <= mem_wdata;
        end
    end

    assign req_tag = req_address[31 -: tag_bits];
    assign req_idx = req_address[offset_bits +: set_bits];

    // tag compare across the set
    always_comb begin
        hit_vec = '0;
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (way_valid[w] && way_tags[w] == req_tag) begin
                hit_vec[w] = 1'b1;
                hit_way    = way_t'(w);
            end
        end
    end

    assign hit          = |hit_vec;
    assign way_sel      = way_sel_lru ? lru_way : hit_way;
    assign victim_dirty = way_valid[lru_way] & way_dirty[lru_way];
    assign line_in      = line_from_mem ? pmem_rdata : req_wdata;
    assign mem_rdata    = way_lines[way_sel];

    // victim snapshot taken in lookup for the write-back
    always_ff @(posedge clk) begin
        if (load_wb) begin
            wb_address <= {way_tags[way_sel], req_idx, {offset_bits{1'b0}}};
            wb_line    <= way_lines[way_sel];
        end
    end

    assign pmem_address = addr_from_wb ? wb_address
                                       : {req_address[31:offset_bits], {offset_bits{1'b0}}};
    assign pmem_wdata   = wb_line;

    line_array array0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (req_idx),
        .way        (way_sel),
        .tag_in     (req_tag),
        .line_in    (line_in),
        .load_line  (load_line),
        .load_valid (load_valid),
        .valid_in   (1'b1),
        .load_dirty (load_dirty),
        .dirty_in   (dirty_in),
        .tags       (way_tags),
        .lines      (way_lines),
        .valids     (way_valid),
        .dirties    (way_dirty)
    );

    pseudo_lru lru0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .index      (req_idx),
        .load_lru   (load_lru),
        .access_way (way_sel),
        .victim     (lru_way)
    );

    // fills only go to the victim so a line never sits in two ways
    a_single_hit: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hit_vec))
        else $error("more than one way hits in set %0d", req_idx);

endmodule

`default_nettype wire

// ==== rtl/l2cache_pkg.sv ====
`default_nettype none

package l2cache_pkg;

    // line and address geometry
    localparam int offset_bits = 5;
    localparam int set_bits    = 3;
    localparam int way_bits    = 2;
    localparam int tag_bits    = 32 - offset_bits - set_bits;

    localparam int num_sets = 8;
    localparam int num_ways = 4;

    // byte address as seen on both ports
    typedef logic [31:0] addr_t;

    // one full cache line
    typedef logic [255:0] line_t;

    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [set_bits-1:0] idx_t;
    typedef logic [way_bits-1:0] way_t;

    // tree bits of one set with [0] the root, [1] the left pair and [2] the right pair
    typedef logic [2:0] plru_t;

endpackage

`default_nettype wire

// ==== rtl/line_array.sv ====
`default_nettype none

module line_array (
    input  logic                                              clk,
    input  logic                                              arst_n,
    input  l2cache_pkg::idx_t                                 index,
    input  l2cache_pkg::way_t                                 way,
    input  l2cache_pkg::tag_t                                 tag_in,
    input  l2cache_pkg::line_t                                line_in,
    input  logic                                              load_line,
    input  logic                                              load_valid,
    input  logic                                              valid_in,
    input  logic                                              load_dirty,
    input  logic                                              dirty_in,
    output l2cache_pkg::tag_t  [l2cache_pkg::num_ways-1:0]    tags,
    output l2cache_pkg::line_t [l2cache_pkg::num_ways-1:0]    lines,
    output logic               [l2cache_pkg::num_ways-1:0]    valids,
    output logic               [l2cache_pkg::num_ways-1:0]    dirties
);
    import l2cache_pkg::*;

    tag_t                tag_mem   [num_sets][num_ways];
    line_t               line_mem  [num_sets][num_ways];
    logic [num_ways-1:0] valid_mem [num_sets];
    logic [num_ways-1:0] dirty_mem [num_sets];

    // tag and line are always written together
    always_ff @(posedge clk) begin
        if (load_line) begin
            tag_mem[index][way]  <= tag_in;
            line_mem[index][way] <= line_in;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[s] <= '0;
                dirty_mem[s] <= '0;
            end
        end else begin
            if (load_valid) begin
                valid_mem[index][way] <= valid_in;
            end
            if (load_dirty) begin
                dirty_mem[index][way] <= dirty_in;
            end
        end
    end

    // whole set visible at once for the tag compare
    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            tags[w]  = tag_mem[index][w];
            lines[w] = line_mem[index][w];
        end
        valids  = valid_mem[index];
        dirties = dirty_mem[index];
    end

endmodule

`default_nettype wire

// ==== rtl/pseudo_lru.sv ====
`default_nettype none

module pseudo_lru (
    input  logic              clk,
    input  logic              arst_n,
    input  l2cache_pkg::idx_t index,
    input  logic              load_lru,
    input  l2cache_pkg::way_t access_way,
    output l2cache_pkg::way_t victim
);
    import l2cache_pkg::*;

    plru_t lru_mem [num_sets];
    plru_t cur_bits;
    plru_t next_bits;

    assign cur_bits = lru_mem[index];

    // bits point toward the victim; root 0 means the left pair
    always_comb begin
        if (cur_bits[0]) begin
            victim = {1'b1, cur_bits[2]};
        end else begin
            victim = {1'b0, cur_bits[1]};
        end
    end

    // turn the root and the touched pair away from the accessed way
    always_comb begin
        next_bits    = cur_bits;
        next_bits[0] = ~access_way[1];
        if (access_way[1]) begin
            next_bits[2] = ~access_way[0];
        end else begin
            next_bits[1] = ~access_way[0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < num_sets; s++) begin
                lru_mem[s] <= '0;
            end
        end else if (load_lru) begin
            lru_mem[index] <= next_bits;
        end
    end

endmodule

`default_nettype wire

// ==== verification/l2cache_tb.sv ====
`default_nettype none

module l2cache_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import l2cache_pkg::*;

    localparam int          period       = 40;
    localparam int          reset_cycles = 5;
    localparam int          max_latency  = 6;
    localparam logic [15:0] seed         = 16'd62980;
    // write-back, fill and three lookups in the worst access
    localparam int access_cycles = 2 * (max_latency + 3) + 4;
    localparam int max_accesses  = 30;
    localparam int worst_cycles  = reset_cycles + 10 + max_accesses * access_cycles;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       mem_req;
    logic       mem_write;
    addr_t      mem_address;
    line_t      mem_wdata;
    logic       mem_resp;
    line_t      mem_rdata;
    logic       pmem_read;
    logic       pmem_write;
    addr_t      pmem_address;
    line_t      pmem_wdata;
    line_t      pmem_rdata;
    logic       pmem_resp;
    logic [2:0] latency;

    logic [15:0] lfsr_state;
    int          errors    = 0;
    int          checks    = 0;
    int          tests_run = 0;
    logic        req_seen  = 1'b0;

    // memory activity seen during the current access
    logic  read_seen;
    logic  write_seen;
    logic  write_first;
    addr_t read_addr;
    addr_t write_addr;
    line_t write_data;

    // reference contents and cache model
    addr_t      ref_addr [64];
    line_t      ref_line [64];
    int         ref_count = 0;
    addr_t      model_tag   [num_sets][num_ways];
    logic       model_valid [num_sets][num_ways];
    logic       model_dirty [num_sets][num_ways];
    logic [2:0] model_tree  [num_sets];

    l2cache dut0 (.*);

    pmem_model pmem0 (.*);

    always #(period / 2) clk = ~clk;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic line_t random_line();
        line_t v;
        for (int i = 0; i < 256; i++) begin
            v[i] = next_bit();
        end
        return v;
    endfunction

    function automatic logic [2:0] random_latency();
        logic [2:0] r;
        for (int i = 0; i < 3; i++) begin
            r[i] = next_bit();
        end
        return 3'(r % max_latency) + 3'd1;
    endfunction

    function automatic line_t expected_line(input addr_t la);
        line_t v;
        v = {8{la}};
        for (int i = 0; i < ref_count; i++) begin
            if (ref_addr[i] == la) begin
                v = ref_line[i];
            end
        end
        return v;
    endfunction

    function automatic void record_ref(input addr_t la, input line_t v);
        for (int i = 0; i < ref_count; i++) begin
            if (ref_addr[i] == la) begin
                ref_line[i] = v;
                return;
            end
        end
        ref_addr[ref_count] = la;
        ref_line[ref_count] = v;
        ref_count++;
    endfunction

    function automatic int find_way(input int set, input addr_t la);
        int found;
        found = -1;
        for (int w = 0; w < num_ways; w++) begin
            if (model_valid[set][w] && model_tag[set][w] == la) begin
                found = w;
            end
        end
        return found;
    endfunction

    // root set means the victim sits in ways 2 and 3
    function automatic int victim_way(input int set);
        if (model_tree[set][0]) begin
            return 2 + int'(model_tree[set][2]);
        end
        return int'(model_tree[set][1]);
    endfunction

    function automatic void touch_way(input int set, input int way);
        model_tree[set][0] = (way < 2);
        if (way < 2) begin
            model_tree[set][1] = (way == 0);
        end else begin
            model_tree[set][2] = (way == 2);
        end
    endfunction

    task automatic expect_equal(input string name, input line_t got, input line_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s: got %0h expected %0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic require(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("error: %s", what);
            errors++;
        end
    endtask

    // strobe one request and wait for mem_resp
    task automatic drive_access(input logic wr, input addr_t addr, input line_t wdata,
                                output line_t rdata, output int cycles);
        read_seen   = 1'b0;
        write_seen  = 1'b0;
        write_first = 1'b0;
        cycles      = 0;
        latency     = random_latency();
        mem_req     = 1'b1;
        mem_write   = wr;
        mem_address = addr;
        mem_wdata   = wdata;
        req_seen    = 1'b1;
        do begin
            @(negedge clk);
            // request fields are valid only in the strobe cycle
            mem_req     = 1'b0;
            mem_write   = 1'b0;
            mem_address = ~addr;
            mem_wdata   = ~wdata;
            cycles++;
            if (pmem_write && !write_seen) begin
                write_seen  = 1'b1;
                write_addr  = pmem_address;
                write_data  = pmem_wdata;
                write_first = !read_seen;
            end
            if (pmem_read && !read_seen) begin
                read_seen = 1'b1;
                read_addr = pmem_address;
            end
        end while (!mem_resp);
        rdata = mem_rdata;
        // cache is back in idle after this edge
        @(negedge clk);
    endtask

    task automatic verify_access(input logic wr, input addr_t addr, input line_t wdata);
        addr_t la;
        int    set;
        int    way;
        logic  exp_hit;
        logic  exp_wb;
        addr_t wb_addr;
        line_t exp_rd;
        line_t rdata;
        int    cycles;
        la      = {addr[31:offset_bits], {offset_bits{1'b0}}};
        set     = int'(addr[offset_bits +: set_bits]);
        way     = find_way(set, la);
        exp_hit = (way >= 0);
        exp_wb  = 1'b0;
        exp_rd  = expected_line(la);
        if (!exp_hit) begin
            way    = victim_way(set);
            exp_wb = model_valid[set][way] && model_dirty[set][way];
            wb_addr = model_tag[set][way];
        end
        drive_access(wr, addr, wdata, rdata, cycles);
        if (exp_hit) begin
            require(cycles == 1, "hit not answered one clock after the strobe");
            require(!read_seen && !write_seen, "memory accessed on a hit");
        end else if (wr) begin
            require(!read_seen, "line fetched on a write miss");
        end else begin
            require(read_seen, "no fill on a read miss");
            expect_equal("pmem_address", line_t'(read_addr), line_t'(la));
        end
        if (!wr) begin
            expect_equal("mem_rdata", rdata, exp_rd);
        end
        if (exp_wb) begin
            require(write_seen, "dirty victim not written back");
            require(write_first, "fill started before the write-back");
            expect_equal("pmem_address", line_t'(write_addr), line_t'(wb_addr));
            expect_equal("pmem_wdata", write_data, expected_line(wb_addr));
            expect_equal("pmem_model line", pmem0.stored_line(wb_addr),
                         expected_line(wb_addr));
        end else begin
            require(!write_seen, "write-back without a dirty victim");
        end
        if (!exp_hit) begin
            model_tag[set][way]   = la;
            model_valid[set][way] = 1'b1;
            model_dirty[set][way] = 1'b0;
        end
        if (wr) begin
            model_dirty[set][way] = 1'b1;
            record_ref(la, wdata);
        end
        touch_way(set, way);
    endtask

    task automatic finish_test(input string name, input int err0);
        tests_run++;
        $display("test %0d %s: %0d errors", tests_run, name, errors - err0);
    endtask

    a_quiet_before_req: assert property (@(posedge clk) disable iff (!arst_n)
        !req_seen |-> !(mem_resp || pmem_read || pmem_write))
        else begin
            $display("cache output active before the first request");
            errors++;
        end

    a_pmem_addr_steady: assert property (@(posedge clk) disable iff (!arst_n)
        (pmem_read || pmem_write) && ($past(pmem_read) || $past(pmem_write))
        |-> $stable(pmem_address))
        else begin
            $display("pmem_address changed while a memory request was held");
            errors++;
        end

    initial begin
        #(period * (worst_cycles + 200));
        $display("watchdog: the tests did not finish in the expected time");
        $display("Something failed");
        $finish;
    end

    initial begin
        int err0;
        lfsr_state  = seed;
        arst_n      = 1'b0;
        mem_req     = 1'b0;
        mem_write   = 1'b0;
        mem_address = '0;
        mem_wdata   = '0;
        latency     = 3'd1;
        for (int s = 0; s < num_sets; s++) begin
            model_tree[s] = '0;
            for (int w = 0; w < num_ways; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w]   = '0;
            end
        end
        repeat (reset_cycles) @(negedge clk);
        arst_n = 1'b1;

        err0 = errors;
        repeat (4) @(negedge clk);
        require(!mem_resp && !pmem_read && !pmem_write, "cache busy after reset");
        finish_test("idle after reset", err0);

        err0 = errors;
        verify_access(1'b0, 32'h0000_1234, '0);
        finish_test("read miss", err0);

        err0 = errors;
        verify_access(1'b0, 32'h0000_1234, '0);
        finish_test("read hit", err0);

        err0 = errors;
        verify_access(1'b1, 32'h0000_1234, random_line());
        verify_access(1'b0, 32'h0000_1234, '0);
        verify_access(1'b1, 32'h0000_2040, random_line());
        verify_access(1'b0, 32'h0000_2040, '0);
        finish_test("write hit and write miss", err0);

        // fill the four ways of set 3 and touch two so a fifth line evicts the LRU way
        err0 = errors;
        for (int i = 1; i <= 4; i++) begin
            verify_access(1'b0, {12'(i), 20'h00060}, '0);
        end
        verify_access(1'b0, {12'd1, 20'h00060}, '0);
        verify_access(1'b0, {12'd3, 20'h00060}, '0);
        verify_access(1'b0, {12'd5, 20'h00060}, '0);
        verify_access(1'b0, {12'd2, 20'h00060}, '0);
        require(read_seen, "evicted line answered without a fill");
        finish_test("lru eviction", err0);

        // with all ways of set 5 dirty each miss writes a victim back
        err0 = errors;
        for (int i = 1; i <= 4; i++) begin
            verify_access(1'b1, {12'(i), 20'h000A0}, random_line());
        end
        verify_access(1'b0, {12'd5, 20'h000A0}, '0);
        verify_access(1'b1, {12'd6, 20'h000A0}, random_line());
        verify_access(1'b0, {12'd1, 20'h000A0}, '0);
        finish_test("dirty write-back", err0);

        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/pmem_model.sv ====
`default_nettype none

module pmem_model (
    input  logic               clk,
    input  logic               arst_n,
    input  logic [2:0]         latency,
    input  logic               pmem_read,
    input  logic               pmem_write,
    input  l2cache_pkg::addr_t pmem_address,
    input  l2cache_pkg::line_t pmem_wdata,
    output l2cache_pkg::line_t pmem_rdata,
    output logic               pmem_resp
);
    timeunit 1ns;
    timeprecision 1ps;
    import l2cache_pkg::*;

    localparam int max_lines = 32;

    addr_t      wr_addr [max_lines];
    line_t      wr_line [max_lines];
    int         wr_count = 0;
    logic       busy;
    logic [2:0] count;

    // unwritten lines read back as their own address repeated
    function automatic line_t stored_line(input addr_t addr);
        line_t v;
        v = {8{addr}};
        for (int i = 0; i < wr_count; i++) begin
            if (wr_addr[i] == addr) begin
                v = wr_line[i];
            end
        end
        return v;
    endfunction

    function automatic void record_line(input addr_t addr, input line_t v);
        for (int i = 0; i < wr_count; i++) begin
            if (wr_addr[i] == addr) begin
                wr_line[i] = v;
                return;
            end
        end
        wr_addr[wr_count] = addr;
        wr_line[wr_count] = v;
        wr_count++;
    endfunction

    // latency is taken when the request level is first seen
    always @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            busy       <= 1'b0;
            count      <= '0;
        end else begin
            pmem_resp <= 1'b0;
            if (pmem_resp) begin
                busy <= 1'b0;
            end else if (!busy && (pmem_read || pmem_write)) begin
                busy  <= 1'b1;
                count <= latency;
            end else if (busy) begin
                if (count <= 3'd1) begin
                    pmem_resp <= 1'b1;
                    if (pmem_write) begin
                        record_line(pmem_address, pmem_wdata);
                    end else begin
                        pmem_rdata <= stored_line(pmem_address);
                    end
                end else begin
                    count <= count - 3'd1;
                end
            end
        end
    end

endmodule

`default_nettype wire
